//--- include/datapath_settings.svh
`ifndef DATAPATH_SETTINGS_SVH
`define DATAPATH_SETTINGS_SVH

// ****************************************
// Datapath sizing
// ****************************************

// Width of the bus, the general registers, MDR, Y and Z.
`define DATA_WIDTH 32

// Number of general registers.
`define REG_COUNT 16

// Bits needed to name one general register.
`define REG_INDEX_WIDTH 4

`endif

//--- hw/datapathPkg.sv
package datapathPkg;

    // ****************************************
    // Instruction word layout
    // ****************************************

    // Opcode field.
    localparam int opcodeMsb = 31;
    localparam int opcodeLsb = 27;

    // Destination register.
    localparam int raMsb = 26;
    localparam int raLsb = 23;

    // First source register.
    localparam int rbMsb = 22;
    localparam int rbLsb = 19;

    // Second source register.
    localparam int rcMsb = 18;
    localparam int rcLsb = 15;

    // ALU opcodes. Values not listed are illegal.
    typedef enum logic [4:0] {
        opAdd = 5'd3,
        opSub = 5'd4,
        opAnd = 5'd5,
        opOr  = 5'd6,
        opShr = 5'd7,
        opShl = 5'd8,
        opNeg = 5'd16,
        opNot = 5'd17
    } aluOpT;

    // Sequencer steps.
    typedef enum logic [2:0] {
        sIdle,
        sLoadWrite,
        sFetchIr,
        sReadB,
        sExecute,
        sWriteBack
    } seqStateT;

    // Bus driver for the current cycle.
    typedef enum logic [1:0] {
        busNone,
        busMdr,
        busReg,
        busZ
    } busSrcT;

endpackage

//--- hw/controlSequencer.sv
`timescale 1ns/1ns
`include "datapath_settings.svh"

module controlSequencer (
    input  logic                          Clock,
    input  logic                          rstN,
    input  logic                          loadValid,
    input  logic [`REG_INDEX_WIDTH-1:0]   loadReg,
    input  logic [`DATA_WIDTH-1:0]        loadData,
    input  logic                          cmdValid,
    input  logic [`DATA_WIDTH-1:0]        cmdWord,
    input  logic [`DATA_WIDTH-1:0]        busValue,
    output logic                          busy,
    output logic                          done,
    output logic [`REG_INDEX_WIDTH-1:0]   resultReg,
    output logic                          mdrIn,
    output logic [`DATA_WIDTH-1:0]        mdrData,
    output datapathPkg::busSrcT           busSel,
    output logic [`REG_INDEX_WIDTH-1:0]   regSel,
    output logic                          regWrite,
    output logic                          yIn,
    output logic                          zIn,
    output datapathPkg::aluOpT            aluOp
);
    import datapathPkg::*;

    seqStateT                      state;
    seqStateT                      nextState;
    logic [`DATA_WIDTH-1:0]        ir;
    logic [`REG_INDEX_WIDTH-1:0]   loadTarget;
    logic [`REG_INDEX_WIDTH-1:0]   ra;
    logic [`REG_INDEX_WIDTH-1:0]   rb;
    logic [`REG_INDEX_WIDTH-1:0]   rc;
    logic                          opLegal;

    // ****************************************
    // Instruction decode
    // ****************************************
    assign aluOp = aluOpT'(ir[opcodeMsb:opcodeLsb]);
    assign ra    = ir[raMsb:raLsb];
    assign rb    = ir[rbMsb:rbLsb];
    assign rc    = ir[rcMsb:rcLsb];

    always_comb begin
        case (aluOp)
            opAdd, opSub, opAnd, opOr, opShr, opShl, opNeg, opNot: opLegal = 1'b1;
            default: opLegal = 1'b0;
        endcase
    end

    // Load wins when both strobes arrive together.
    assign mdrData = loadValid ? loadData : cmdWord;
    assign mdrIn   = (state == sIdle) && (loadValid || cmdValid);
    assign busy    = (state != sIdle);

    // ****************************************
    // Step control
    // ****************************************
    always_comb begin
        nextState = state;
        busSel    = busNone;
        regSel    = '0;
        regWrite  = 1'b0;
        yIn       = 1'b0;
        zIn       = 1'b0;
        case (state)
            sIdle: begin
                if (loadValid) begin
                    nextState = sLoadWrite;
                end else if (cmdValid) begin
                    nextState = sFetchIr;
                end
            end
            sLoadWrite: begin
                busSel    = busMdr;
                regSel    = loadTarget;
                regWrite  = 1'b1;
                nextState = sIdle;
            end
            sFetchIr: begin
                busSel    = busMdr;
                nextState = sReadB;
            end
            sReadB: begin
                busSel = busReg;
                regSel = rb;
                // Illegal opcodes abort here.
                yIn       = opLegal;
                nextState = opLegal ? sExecute : sIdle;
            end
            sExecute: begin
                busSel    = busReg;
                regSel    = rc;
                zIn       = 1'b1;
                nextState = sWriteBack;
            end
            sWriteBack: begin
                busSel    = busZ;
                regSel    = ra;
                regWrite  = 1'b1;
                nextState = sIdle;
            end
            default: nextState = sIdle;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state     <= sIdle;
            done      <= 1'b0;
            resultReg <= '0;
        end else begin
            state <= nextState;
            done  <= (state == sWriteBack);
            if (state == sWriteBack) begin
                resultReg <= ra;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (state == sFetchIr) begin
            ir <= busValue;
        end
        if ((state == sIdle) && loadValid) begin
            loadTarget <= loadReg;
        end
    end

endmodule

//--- hw/registerBus.sv
`timescale 1ns/1ns
`include "datapath_settings.svh"

module registerBus (
    input  logic                          Clock,
    input  logic                          rstN,
    input  logic                          mdrIn,
    input  logic [`DATA_WIDTH-1:0]        mdrData,
    input  datapathPkg::busSrcT           busSel,
    input  logic [`REG_INDEX_WIDTH-1:0]   regSel,
    input  logic                          regWrite,
    input  logic [`DATA_WIDTH-1:0]        zValue,
    output logic [`DATA_WIDTH-1:0]        busValue
);
    import datapathPkg::*;

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0] mdr;

    // ****************************************
    // Shared bus
    // ****************************************

    // Only one source drives the bus per cycle.
    always_comb begin
        case (busSel)
            busMdr:  busValue = mdr;
            busReg:  busValue = regs[regSel];
            busZ:    busValue = zValue;
            default: busValue = '0;
        endcase
    end

    // ****************************************
    // MDR and general registers
    // ****************************************
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            mdr <= '0;
        end else if (mdrIn) begin
            mdr <= mdrData;
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite) begin
            // Writeback always comes from the bus.
            regs[regSel] <= busValue;
        end
    end

endmodule

//--- hw/aluUnit.sv
`timescale 1ns/1ns
`include "datapath_settings.svh"

module aluUnit (
    input  logic                    Clock,
    input  logic                    rstN,
    input  logic [`DATA_WIDTH-1:0]  busValue,
    input  logic                    yIn,
    input  logic                    zIn,
    input  datapathPkg::aluOpT      aluOp,
    output logic [`DATA_WIDTH-1:0]  zValue
);
    import datapathPkg::*;

    localparam int shiftWidth = $clog2(`DATA_WIDTH);

    logic [`DATA_WIDTH-1:0] y;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [shiftWidth-1:0]  shiftAmount;

    // Shifts use only the low bits of the second operand.
    assign shiftAmount = busValue[shiftWidth-1:0];

    // ****************************************
    // Combinational ALU
    // ****************************************

    // Y is the first operand, the bus is the second.
    always_comb begin
        case (aluOp)
            opAdd:   aluResult = y + busValue;
            opSub:   aluResult = y - busValue;
            opAnd:   aluResult = y & busValue;
            opOr:    aluResult = y | busValue;
            opShr:   aluResult = y >> shiftAmount;
            opShl:   aluResult = y << shiftAmount;
            opNeg:   aluResult = -y;
            opNot:   aluResult = ~y;
            default: aluResult = '0;
        endcase
    end

    // ****************************************
    // Operand and result registers
    // ****************************************
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            y <= '0;
        end else if (yIn) begin
            y <= busValue;
        end
    end

    // Z holds its value until the next execute step.
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            zValue <= '0;
        end else if (zIn) begin
            zValue <= aluResult;
        end
    end

endmodule

//--- hw/busDatapath.sv
`timescale 1ns/1ns
`include "datapath_settings.svh"

module busDatapath (
    input  logic                          Clock,
    input  logic                          rstN,
    input  logic                          loadValid,
    input  logic [`REG_INDEX_WIDTH-1:0]   loadReg,
    input  logic [`DATA_WIDTH-1:0]        loadData,
    input  logic                          cmdValid,
    input  logic [`DATA_WIDTH-1:0]        cmdWord,
    output logic                          busy,
    output logic                          done,
    output logic [`REG_INDEX_WIDTH-1:0]   resultReg,
    output logic [`DATA_WIDTH-1:0]        resultValue
);
    import datapathPkg::*;

    logic                          mdrIn;
    logic [`DATA_WIDTH-1:0]        mdrData;
    busSrcT                        busSel;
    logic [`REG_INDEX_WIDTH-1:0]   regSel;
    logic                          regWrite;
    logic [`DATA_WIDTH-1:0]        busValue;
    logic                          yIn;
    logic                          zIn;
    aluOpT                         aluOp;

    controlSequencer i_controlSequencer (
        .Clock     (Clock),
        .rstN      (rstN),
        .loadValid (loadValid),
        .loadReg   (loadReg),
        .loadData  (loadData),
        .cmdValid  (cmdValid),
        .cmdWord   (cmdWord),
        .busValue  (busValue),
        .busy      (busy),
        .done      (done),
        .resultReg (resultReg),
        .mdrIn     (mdrIn),
        .mdrData   (mdrData),
        .busSel    (busSel),
        .regSel    (regSel),
        .regWrite  (regWrite),
        .yIn       (yIn),
        .zIn       (zIn),
        .aluOp     (aluOp)
    );

    // Z feeds the bus and is also the reported result.
    registerBus i_registerBus (
        .Clock    (Clock),
        .rstN     (rstN),
        .mdrIn    (mdrIn),
        .mdrData  (mdrData),
        .busSel   (busSel),
        .regSel   (regSel),
        .regWrite (regWrite),
        .zValue   (resultValue),
        .busValue (busValue)
    );

    aluUnit i_aluUnit (
        .Clock    (Clock),
        .rstN     (rstN),
        .busValue (busValue),
        .yIn      (yIn),
        .zIn      (zIn),
        .aluOp    (aluOp),
        .zValue   (resultValue)
    );

endmodule

//--- tb/busDatapathTb.sv
`timescale 1ns/1ns
`include "datapath_settings.svh"

module busDatapathTb;
    import datapathPkg::*;

    typedef enum logic [1:0] {
        kLoad,
        kLoadRandom,
        kInstr,
        kBusyStrobe
    } entryKindT;

    // A load uses ra as its target. A busy strobe targets rb with value.
    typedef struct packed {
        entryKindT                   kind;
        logic [4:0]                  op;
        logic [`REG_INDEX_WIDTH-1:0] ra;
        logic [`REG_INDEX_WIDTH-1:0] rb;
        logic [`REG_INDEX_WIDTH-1:0] rc;
        logic [`DATA_WIDTH-1:0]      value;
    } stimT;

    localparam int tableLength   = 27;
    localparam int doneWait      = 8;
    localparam int watchdogCycles = tableLength * 10 + 20;

    logic                        Clock;
    logic                        rstN;
    logic                        loadValid;
    logic [`REG_INDEX_WIDTH-1:0] loadReg;
    logic [`DATA_WIDTH-1:0]      loadData;
    logic                        cmdValid;
    logic [`DATA_WIDTH-1:0]      cmdWord;
    logic                        busy;
    logic                        done;
    logic [`REG_INDEX_WIDTH-1:0] resultReg;
    logic [`DATA_WIDTH-1:0]      resultValue;

    stimT                   stim [tableLength];
    logic [`DATA_WIDTH-1:0] model [`REG_COUNT];
    logic [31:0]            lfsrState = 32'h47a33fc1;
    int                     valueErrors = 0;
    int                     otherErrors = 0;

    busDatapath i_busDatapath (
        .Clock       (Clock),
        .rstN        (rstN),
        .loadValid   (loadValid),
        .loadReg     (loadReg),
        .loadData    (loadData),
        .cmdValid    (cmdValid),
        .cmdWord     (cmdWord),
        .busy        (busy),
        .done        (done),
        .resultReg   (resultReg),
        .resultValue (resultValue)
    );

    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    // ****************************************
    // Reference model and helpers
    // ****************************************

    // Galois LFSR, one step per bit taken.
    task automatic takeRandomWord(output logic [`DATA_WIDTH-1:0] word);
        for (int i = 0; i < `DATA_WIDTH; i++) begin
            word = {word[`DATA_WIDTH-2:0], lfsrState[0]};
            if (lfsrState[0]) begin
                lfsrState = (lfsrState >> 1) ^ 32'h80200003;
            end else begin
                lfsrState = lfsrState >> 1;
            end
        end
    endtask

    function automatic logic [`DATA_WIDTH-1:0] makeWord(input stimT s);
        return {s.op, s.ra, s.rb, s.rc, 15'h4d2b};
    endfunction

    function automatic bit legalOp(input logic [4:0] op);
        case (op)
            opAdd, opSub, opAnd, opOr, opShr, opShl, opNeg, opNot: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // First operand is R[rb], second is R[rc].
    function automatic logic [`DATA_WIDTH-1:0] expectedResult(input logic [4:0] op,
        input logic [`DATA_WIDTH-1:0] b, input logic [`DATA_WIDTH-1:0] c);
        case (op)
            opAdd:   return b + c;
            opSub:   return b - c;
            opAnd:   return b & c;
            opOr:    return b | c;
            opShr:   return b >> c[4:0];
            opShl:   return b << c[4:0];
            opNeg:   return 32'd0 - b;
            opNot:   return ~b;
            default: return '0;
        endcase
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
        input logic [31:0] expected);
        assert (got === expected) else begin
            valueErrors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic waitIdle();
        while (busy) begin
            @(negedge Clock);
        end
    endtask

    task automatic runLoad(input stimT s);
        logic [`DATA_WIDTH-1:0] word;
        word = s.value;
        if (s.kind == kLoadRandom) begin
            takeRandomWord(word);
        end
        waitIdle();
        loadReg   = s.ra;
        loadData  = word;
        loadValid = 1'b1;
        model[s.ra] = word;
        // Busy covers the write step only and done never rises.
        for (int k = 0; k < 2; k++) begin
            @(negedge Clock);
            loadValid = 1'b0;
            checkValue("busy", 32'(busy), (k == 0) ? 32'd1 : 32'd0);
            assert (!done) else begin
                otherErrors++;
                $display("At %0t ns a register load raised done.", $time);
            end
        end
    endtask

    task automatic runInstr(input stimT s);
        logic [`DATA_WIDTH-1:0] expected;
        int                     cycles;
        expected = expectedResult(s.op, model[s.rb], model[s.rc]);
        waitIdle();
        cmdWord  = makeWord(s);
        cmdValid = 1'b1;
        @(negedge Clock);
        cmdValid = 1'b0;
        if (s.kind == kBusyStrobe) begin
            // Both strobes arrive while the sequencer is busy.
            loadValid = 1'b1;
            loadReg   = s.rb;
            loadData  = s.value;
            cmdValid  = 1'b1;
            cmdWord   = {opAdd, s.rb, s.rb, s.rb, 15'h0};
            @(negedge Clock);
            loadValid = 1'b0;
            cmdValid  = 1'b0;
        end
        if (legalOp(s.op)) begin
            cycles = 0;
            while (!done && cycles < doneWait) begin
                checkValue("busy", 32'(busy), 32'd1);
                @(negedge Clock);
                cycles++;
            end
            assert (done) else begin
                otherErrors++;
                $display("At %0t ns no done strobe arrived for entry with ra %0d.",
                    $time, s.ra);
            end
            if (done) begin
                checkValue("busy", 32'(busy), 32'd0);
                checkValue("resultReg", 32'(resultReg), 32'(s.ra));
                checkValue("resultValue", resultValue, expected);
            end
            model[s.ra] = expected;
            repeat ((s.kind == kBusyStrobe) ? 5 : 1) begin
                @(negedge Clock);
                assert (!done) else begin
                    otherErrors++;
                    $display("At %0t ns an extra done strobe appeared.", $time);
                end
            end
        end else begin
            repeat (5) begin
                @(negedge Clock);
                assert (!done) else begin
                    otherErrors++;
                    $display("At %0t ns an illegal opcode raised done.", $time);
                end
            end
        end
    endtask

    // ****************************************
    // Stimulus table and main sequence
    // ****************************************
    initial begin
        rstN      = 1'b0;
        loadValid = 1'b0;
        loadReg   = '0;
        loadData  = '0;
        cmdValid  = 1'b0;
        cmdWord   = '0;

        stim[0]  = '{kInstr, opNot, 4'd12, 4'd11, 4'd0, 32'h0};
        stim[1]  = '{kLoad, 5'd0, 4'd1, 4'd0, 4'd0, 32'hffff_fff0};
        stim[2]  = '{kLoad, 5'd0, 4'd2, 4'd0, 4'd0, 32'h0000_0025};
        stim[3]  = '{kLoadRandom, 5'd0, 4'd3, 4'd0, 4'd0, 32'h0};
        stim[4]  = '{kLoadRandom, 5'd0, 4'd4, 4'd0, 4'd0, 32'h0};
        stim[5]  = '{kInstr, opAdd, 4'd5, 4'd1, 4'd2, 32'h0};
        stim[6]  = '{kInstr, opSub, 4'd6, 4'd2, 4'd1, 32'h0};
        stim[7]  = '{kInstr, opAnd, 4'd7, 4'd3, 4'd4, 32'h0};
        stim[8]  = '{kInstr, opOr, 4'd8, 4'd3, 4'd4, 32'h0};
        stim[9]  = '{kLoad, 5'd0, 4'd9, 4'd0, 4'd0, 32'h0000_0123};
        stim[10] = '{kInstr, opShl, 4'd10, 4'd3, 4'd9, 32'h0};
        stim[11] = '{kInstr, opShr, 4'd11, 4'd4, 4'd9, 32'h0};
        stim[12] = '{kInstr, opNeg, 4'd13, 4'd3, 4'd9, 32'h0};
        stim[13] = '{kInstr, opNot, 4'd14, 4'd4, 4'd1, 32'h0};
        stim[14] = '{kInstr, opAdd, 4'd5, 4'd5, 4'd5, 32'h0};
        stim[15] = '{kInstr, opSub, 4'd6, 4'd5, 4'd6, 32'h0};
        stim[16] = '{kInstr, 5'd9, 4'd1, 4'd2, 4'd3, 32'h0};
        stim[17] = '{kInstr, 5'd31, 4'd2, 4'd1, 4'd4, 32'h0};
        stim[18] = '{kInstr, opOr, 4'd0, 4'd1, 4'd2, 32'h0};
        stim[19] = '{kBusyStrobe, opAdd, 4'd15, 4'd3, 4'd4, 32'hdead_beef};
        stim[20] = '{kInstr, opSub, 4'd0, 4'd3, 4'd4, 32'h0};
        stim[21] = '{kLoadRandom, 5'd0, 4'd9, 4'd0, 4'd0, 32'h0};
        stim[22] = '{kInstr, opShl, 4'd10, 4'd4, 4'd9, 32'h0};
        stim[23] = '{kInstr, opShr, 4'd11, 4'd1, 4'd9, 32'h0};
        stim[24] = '{kInstr, opNeg, 4'd12, 4'd12, 4'd0, 32'h0};
        stim[25] = '{kLoad, 5'd0, 4'd0, 4'd0, 4'd0, 32'h8000_0000};
        stim[26] = '{kInstr, opShr, 4'd7, 4'd0, 4'd2, 32'h0};

        for (int r = 0; r < `REG_COUNT; r++) begin
            model[r] = '0;
        end

        repeat (10) @(negedge Clock);
        rstN = 1'b1;
        @(negedge Clock);
        assert (!busy && !done) else begin
            otherErrors++;
            $display("At %0t ns busy or done is high after reset.", $time);
        end

        for (int i = 0; i < tableLength; i++) begin
            case (stim[i].kind)
                kLoad, kLoadRandom: runLoad(stim[i]);
                default: runInstr(stim[i]);
            endcase
        end

        $display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Bound on the whole run.
    initial begin
        repeat (watchdogCycles) @(posedge Clock);
        $display("Watchdog expired after %0d cycles, the run did not finish.", watchdogCycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
hw/datapathPkg.sv
hw/controlSequencer.sv
hw/registerBus.sv
hw/aluUnit.sv
hw/busDatapath.sv
tb/busDatapathTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= busDatapathTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# The log decides pass or fail.
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
